// File: src/vrf_geom_pkg.sv
package vrf_geom_pkg;

   // word and bank geometry
   localparam int word_w     = 32;
   localparam int num_banks  = 4;
   localparam int bank_sel_w = 2;

   // rows per bank and the address widths that follow from it
   localparam int bank_depth = 128;
   localparam int row_w      = 7;
   localparam int addr_w     = row_w + bank_sel_w;

   typedef logic [word_w-1:0] word_t;

   // word address, bank number in the low bits and row above them
   typedef logic [addr_w-1:0] vrf_addr_t;

   typedef logic [row_w-1:0] row_addr_t;

   typedef logic [bank_sel_w-1:0] bank_sel_t;

endpackage

// File: src/vrf_port_pkg.sv
package vrf_port_pkg;

   // words per access on each port
   localparam int quad_words = 4;
   localparam int pair_words = 2;

   // wide port moves four words, narrow port two
   typedef logic [quad_words*vrf_geom_pkg::word_w-1:0] quad_t;
   typedef logic [pair_words*vrf_geom_pkg::word_w-1:0] pair_t;

   // write size decoded from enable mask and address alignment
   // wr_none also stands for any illegal mask or alignment
   typedef enum logic [1:0] {
      wr_none,
      wr_word,
      wr_pair,
      wr_quad
   } wr_size_e;

endpackage

// File: src/vrf_bank.sv
`timescale 1ns/1ps

module vrf_bank #(
   parameter int depth = 128
) (
   input  logic                    clk,
   input  vrf_geom_pkg::row_addr_t rd_a_row,
   input  vrf_geom_pkg::row_addr_t rd_b_row,
   output vrf_geom_pkg::word_t     rd_a_data,
   output vrf_geom_pkg::word_t     rd_b_data,
   input  logic                    wr_a_en,
   input  logic                    wr_b_en,
   input  vrf_geom_pkg::row_addr_t wr_a_row,
   input  vrf_geom_pkg::row_addr_t wr_b_row,
   input  vrf_geom_pkg::word_t     wr_a_data,
   input  vrf_geom_pkg::word_t     wr_b_data
);

   vrf_geom_pkg::word_t mem [depth];

   // registered reads return the contents from before this edge
   always_ff @(posedge clk)
   begin
      rd_a_data <= mem[rd_a_row];
      rd_b_data <= mem[rd_b_row];
   end

   always_ff @(posedge clk)
   begin
      if (wr_a_en)
      begin
         mem[wr_a_row] <= wr_a_data;
      end
      // port b comes last so it wins when both hit one row
      if (wr_b_en)
      begin
         mem[wr_b_row] <= wr_b_data;
      end
   end

endmodule

// File: src/vrf_write_steer.sv
`timescale 1ns/1ps

module vrf_write_steer #(
   parameter int port_words = 4
) (
   input  vrf_geom_pkg::vrf_addr_t                                wr_addr,
   input  logic [port_words-1:0]                                  wr_en,
   input  vrf_geom_pkg::word_t [port_words-1:0]                   wr_data,
   output logic [vrf_geom_pkg::num_banks-1:0]                     bank_en,
   output vrf_geom_pkg::row_addr_t [vrf_geom_pkg::num_banks-1:0]  bank_row,
   output vrf_geom_pkg::word_t [vrf_geom_pkg::num_banks-1:0]      bank_data
);

   localparam int bsw = vrf_geom_pkg::bank_sel_w;
   localparam int aw  = vrf_geom_pkg::addr_w;

   // legal enable patterns, always starting at word 0
   localparam logic [port_words-1:0] word_mask = port_words'(1);
   localparam logic [port_words-1:0] pair_mask = port_words'(3);
   localparam logic [port_words-1:0] full_mask = '1;

   vrf_port_pkg::wr_size_e  wr_size;
   logic [2:0]              word_cnt;
   vrf_geom_pkg::bank_sel_t addr_low;

   assign addr_low = wr_addr[bsw-1:0];

   // pair is checked before quad, on the narrow port both masks are 2'b11
   always_comb
   begin
      wr_size = vrf_port_pkg::wr_none;
      if (wr_en == word_mask)
      begin
         wr_size = vrf_port_pkg::wr_word;
      end
      else if (port_words >= vrf_port_pkg::pair_words && wr_en == pair_mask &&
               !addr_low[0])
      begin
         wr_size = vrf_port_pkg::wr_pair;
      end
      else if (port_words >= vrf_port_pkg::quad_words && wr_en == full_mask &&
               addr_low == '0)
      begin
         wr_size = vrf_port_pkg::wr_quad;
      end
   end

   always_comb
   begin
      case (wr_size)
         vrf_port_pkg::wr_word: word_cnt = 3'd1;
         vrf_port_pkg::wr_pair: word_cnt = 3'd2;
         vrf_port_pkg::wr_quad: word_cnt = 3'd4;
         default:               word_cnt = 3'd0;
      endcase
   end

   // word k lands in bank (a+k) mod 4 at row (a+k) div 4
   always_comb
   begin
      vrf_geom_pkg::vrf_addr_t addr_k;
      vrf_geom_pkg::bank_sel_t sel;
      bank_en   = '0;
      bank_row  = '0;
      bank_data = '0;
      for (int k = 0; k < port_words; k++)
      begin
         addr_k = wr_addr + vrf_geom_pkg::vrf_addr_t'(k);
         sel    = addr_k[bsw-1:0];
         if (k < word_cnt)
         begin
            bank_en[sel]   = 1'b1;
            bank_row[sel]  = addr_k[aw-1:bsw];
            bank_data[sel] = wr_data[k];
         end
      end
   end

endmodule

// File: src/vrf_read_port.sv
`timescale 1ns/1ps

module vrf_read_port #(
   parameter int port_words = 4
) (
   input  logic                                                   clk,
   input  logic                                                   arst_n,
   input  vrf_geom_pkg::vrf_addr_t                                rd_addr,
   output vrf_geom_pkg::row_addr_t [vrf_geom_pkg::num_banks-1:0]  bank_row,
   input  vrf_geom_pkg::word_t [vrf_geom_pkg::num_banks-1:0]      bank_data,
   output vrf_geom_pkg::word_t [port_words-1:0]                   rd_data
);

   localparam int bsw = vrf_geom_pkg::bank_sel_w;
   localparam int aw  = vrf_geom_pkg::addr_w;

   vrf_geom_pkg::bank_sel_t addr_low;
   vrf_geom_pkg::bank_sel_t rd_off;

   assign addr_low = rd_addr[bsw-1:0];

   // bank b holds the word at offset (b - a) mod 4 from the address
   always_comb
   begin
      vrf_geom_pkg::bank_sel_t off;
      vrf_geom_pkg::vrf_addr_t addr_b;
      for (int b = 0; b < vrf_geom_pkg::num_banks; b++)
      begin
         off    = vrf_geom_pkg::bank_sel_t'(b) - addr_low;
         // 9-bit add wraps past 511 back to word 0
         addr_b = rd_addr + vrf_geom_pkg::vrf_addr_t'(off);
         if (off < port_words)
         begin
            bank_row[b] = addr_b[aw-1:bsw];
         end
         else
         begin
            bank_row[b] = '0;
         end
      end
   end

   // offset follows the bank data through its one cycle of latency
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_off <= '0;
      else
         rd_off <= addr_low;
   end

   // rotate so the addressed word sits in the low bits
   always_comb
   begin
      vrf_geom_pkg::bank_sel_t src;
      for (int k = 0; k < port_words; k++)
      begin
         src        = rd_off + vrf_geom_pkg::bank_sel_t'(k);
         rd_data[k] = bank_data[src];
      end
   end

endmodule

// File: src/vector_regfile.sv
`timescale 1ns/1ps

module vector_regfile (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  vrf_geom_pkg::vrf_addr_t               rd0_addr,
   input  vrf_geom_pkg::vrf_addr_t               rd1_addr,
   output vrf_port_pkg::quad_t                   rd0_data,
   output vrf_port_pkg::pair_t                   rd1_data,
   input  vrf_geom_pkg::vrf_addr_t               wr0_addr,
   input  vrf_geom_pkg::vrf_addr_t               wr1_addr,
   input  logic [vrf_port_pkg::quad_words-1:0]   wr0_en,
   input  logic [vrf_port_pkg::pair_words-1:0]   wr1_en,
   input  vrf_port_pkg::quad_t                   wr0_data,
   input  vrf_port_pkg::pair_t                   wr1_data
);

   localparam int nb = vrf_geom_pkg::num_banks;

   logic [nb-1:0]                     wr0_bank_en;
   logic [nb-1:0]                     wr1_bank_en;
   vrf_geom_pkg::row_addr_t [nb-1:0]  wr0_bank_row;
   vrf_geom_pkg::row_addr_t [nb-1:0]  wr1_bank_row;
   vrf_geom_pkg::word_t [nb-1:0]      wr0_bank_data;
   vrf_geom_pkg::word_t [nb-1:0]      wr1_bank_data;

   vrf_geom_pkg::row_addr_t [nb-1:0]  rd0_bank_row;
   vrf_geom_pkg::row_addr_t [nb-1:0]  rd1_bank_row;
   vrf_geom_pkg::word_t [nb-1:0]      rd0_bank_data;
   vrf_geom_pkg::word_t [nb-1:0]      rd1_bank_data;

   // wide ports drive bank port a, narrow ports bank port b
   vrf_write_steer #(.port_words(vrf_port_pkg::quad_words)) wr0_steer (
      .wr_addr(wr0_addr), .wr_en(wr0_en), .wr_data(wr0_data),
      .bank_en(wr0_bank_en), .bank_row(wr0_bank_row), .bank_data(wr0_bank_data)
   );

   vrf_write_steer #(.port_words(vrf_port_pkg::pair_words)) wr1_steer (
      .wr_addr(wr1_addr), .wr_en(wr1_en), .wr_data(wr1_data),
      .bank_en(wr1_bank_en), .bank_row(wr1_bank_row), .bank_data(wr1_bank_data)
   );

   vrf_read_port #(.port_words(vrf_port_pkg::quad_words)) rd0_port (
      .clk(clk), .arst_n(arst_n), .rd_addr(rd0_addr),
      .bank_row(rd0_bank_row), .bank_data(rd0_bank_data), .rd_data(rd0_data)
   );

   vrf_read_port #(.port_words(vrf_port_pkg::pair_words)) rd1_port (
      .clk(clk), .arst_n(arst_n), .rd_addr(rd1_addr),
      .bank_row(rd1_bank_row), .bank_data(rd1_bank_data), .rd_data(rd1_data)
   );

   vrf_bank #(.depth(vrf_geom_pkg::bank_depth)) bank0 (
      .clk(clk),
      .rd_a_row(rd0_bank_row[0]), .rd_a_data(rd0_bank_data[0]),
      .rd_b_row(rd1_bank_row[0]), .rd_b_data(rd1_bank_data[0]),
      .wr_a_en(wr0_bank_en[0]), .wr_a_row(wr0_bank_row[0]), .wr_a_data(wr0_bank_data[0]),
      .wr_b_en(wr1_bank_en[0]), .wr_b_row(wr1_bank_row[0]), .wr_b_data(wr1_bank_data[0])
   );

   vrf_bank #(.depth(vrf_geom_pkg::bank_depth)) bank1 (
      .clk(clk),
      .rd_a_row(rd0_bank_row[1]), .rd_a_data(rd0_bank_data[1]),
      .rd_b_row(rd1_bank_row[1]), .rd_b_data(rd1_bank_data[1]),
      .wr_a_en(wr0_bank_en[1]), .wr_a_row(wr0_bank_row[1]), .wr_a_data(wr0_bank_data[1]),
      .wr_b_en(wr1_bank_en[1]), .wr_b_row(wr1_bank_row[1]), .wr_b_data(wr1_bank_data[1])
   );

   vrf_bank #(.depth(vrf_geom_pkg::bank_depth)) bank2 (
      .clk(clk),
      .rd_a_row(rd0_bank_row[2]), .rd_a_data(rd0_bank_data[2]),
      .rd_b_row(rd1_bank_row[2]), .rd_b_data(rd1_bank_data[2]),
      .wr_a_en(wr0_bank_en[2]), .wr_a_row(wr0_bank_row[2]), .wr_a_data(wr0_bank_data[2]),
      .wr_b_en(wr1_bank_en[2]), .wr_b_row(wr1_bank_row[2]), .wr_b_data(wr1_bank_data[2])
   );

   vrf_bank #(.depth(vrf_geom_pkg::bank_depth)) bank3 (
      .clk(clk),
      .rd_a_row(rd0_bank_row[3]), .rd_a_data(rd0_bank_data[3]),
      .rd_b_row(rd1_bank_row[3]), .rd_b_data(rd1_bank_data[3]),
      .wr_a_en(wr0_bank_en[3]), .wr_a_row(wr0_bank_row[3]), .wr_a_data(wr0_bank_data[3]),
      .wr_b_en(wr1_bank_en[3]), .wr_b_row(wr1_bank_row[3]), .wr_b_data(wr1_bank_data[3])
   );

endmodule

// File: tb/vector_regfile_assert.sv
`timescale 1ns/1ps

module vector_regfile_assert #(
   parameter int port_words = 4
) (
   input logic                                                   clk,
   input logic                                                   arst_n,
   input vrf_geom_pkg::vrf_addr_t                                wr_addr,
   input logic [port_words-1:0]                                  wr_en,
   input logic [vrf_geom_pkg::num_banks-1:0]                     bank_en,
   input vrf_geom_pkg::row_addr_t [vrf_geom_pkg::num_banks-1:0]  bank_row
);

   int   fail_cnt = 0;
   int   exp_cnt;
   logic rows_ok;

   always_comb
   begin
      exp_cnt = 0;
      if (wr_en == port_words'(1))
         exp_cnt = 1;
      else if (port_words >= 2 && wr_en == port_words'(3) && !wr_addr[0])
         exp_cnt = 2;
      else if (port_words == 4 && wr_en == '1 && wr_addr[1:0] == 2'b00)
         exp_cnt = 4;
   end

   // an enabled bank must hold the row of the word that falls in it
   always_comb
   begin
      vrf_geom_pkg::vrf_addr_t addr_k;
      rows_ok = 1'b1;
      for (int k = 0; k < vrf_geom_pkg::num_banks; k++)
      begin
         addr_k = wr_addr + vrf_geom_pkg::vrf_addr_t'(k);
         if (bank_en[addr_k[1:0]] && bank_row[addr_k[1:0]] != addr_k[8:2])
            rows_ok = 1'b0;
      end
   end

   count_a: assert property (@(posedge clk) disable iff (!arst_n)
      exp_cnt != 0 |-> $countones(bank_en) == exp_cnt)
   else
   begin
      $error("enabled bank count does not match the decoded write size");
      fail_cnt++;
   end

   none_a: assert property (@(posedge clk) disable iff (!arst_n)
      exp_cnt == 0 |-> bank_en == '0)
   else
   begin
      $error("illegal or empty write enabled a bank");
      fail_cnt++;
   end

   rows_a: assert property (@(posedge clk) disable iff (!arst_n) rows_ok)
   else
   begin
      $error("enabled bank rows are not consecutive");
      fail_cnt++;
   end

endmodule

// each write steer gets a checker bound into the top level that carries clk
bind vector_regfile vector_regfile_assert #(.port_words(vrf_port_pkg::quad_words)) wr0_steer_chk (
   .clk(clk), .arst_n(arst_n), .wr_addr(wr0_addr), .wr_en(wr0_en),
   .bank_en(wr0_bank_en), .bank_row(wr0_bank_row)
);

bind vector_regfile vector_regfile_assert #(.port_words(vrf_port_pkg::pair_words)) wr1_steer_chk (
   .clk(clk), .arst_n(arst_n), .wr_addr(wr1_addr), .wr_en(wr1_en),
   .bank_en(wr1_bank_en), .bank_row(wr1_bank_row)
);

// File: tb/vector_regfile_tb.sv
`timescale 1ns/1ps

module vector_regfile_tb;

   localparam int max_cycles = 2000;
   localparam int mem_words  = 512;

   typedef struct packed {
      vrf_geom_pkg::vrf_addr_t wr0_addr;
      logic [3:0]              wr0_en;
      vrf_geom_pkg::vrf_addr_t wr1_addr;
      logic [1:0]              wr1_en;
      vrf_geom_pkg::vrf_addr_t rd0_addr;
      vrf_geom_pkg::vrf_addr_t rd1_addr;
   } stim_t;

   logic                    clk;
   logic                    arst_n;
   vrf_geom_pkg::vrf_addr_t rd0_addr;
   vrf_geom_pkg::vrf_addr_t rd1_addr;
   vrf_port_pkg::quad_t     rd0_data;
   vrf_port_pkg::pair_t     rd1_data;
   vrf_geom_pkg::vrf_addr_t wr0_addr;
   vrf_geom_pkg::vrf_addr_t wr1_addr;
   logic [3:0]              wr0_en;
   logic [1:0]              wr1_en;
   vrf_port_pkg::quad_t     wr0_data;
   vrf_port_pkg::pair_t     wr1_data;

   stim_t               stim_q[$];
   vrf_geom_pkg::word_t model [mem_words];
   int                  error_count = 0;

   vector_regfile vector_regfile_inst (
      .clk(clk), .arst_n(arst_n),
      .rd0_addr(rd0_addr), .rd1_addr(rd1_addr),
      .rd0_data(rd0_data), .rd1_data(rd1_data),
      .wr0_addr(wr0_addr), .wr1_addr(wr1_addr),
      .wr0_en(wr0_en), .wr1_en(wr1_en),
      .wr0_data(wr0_data), .wr1_data(wr1_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic add_row(input int w0a, input int w0e, input int w1a, input int w1e,
                          input int r0a, input int r1a);
      stim_t row;
      row.wr0_addr = vrf_geom_pkg::vrf_addr_t'(w0a);
      row.wr0_en   = 4'(w0e);
      row.wr1_addr = vrf_geom_pkg::vrf_addr_t'(w1a);
      row.wr1_en   = 2'(w1e);
      row.rd0_addr = vrf_geom_pkg::vrf_addr_t'(r0a);
      row.rd1_addr = vrf_geom_pkg::vrf_addr_t'(r1a);
      stim_q.push_back(row);
   endtask

   // one word anywhere, a pair at an even address, a quad at a multiple of 4
   task automatic model_write(input int addr, input int mask, input int port_words,
                              input logic [127:0] data);
      int cnt;
      cnt = 0;
      if (mask == 1)
         cnt = 1;
      else if (mask == 3 && addr % 2 == 0)
         cnt = 2;
      else if (port_words == 4 && mask == 15 && addr % 4 == 0)
         cnt = 4;
      for (int k = 0; k < cnt; k++)
      begin
         model[(addr + k) % mem_words] = data[32*k +: 32];
      end
   endtask

   function automatic vrf_port_pkg::quad_t model_quad(input int addr);
      vrf_port_pkg::quad_t q;
      for (int k = 0; k < 4; k++)
      begin
         q[32*k +: 32] = model[(addr + k) % mem_words];
      end
      return q;
   endfunction

   function automatic vrf_port_pkg::pair_t model_pair(input int addr);
      vrf_port_pkg::pair_t p;
      for (int k = 0; k < 2; k++)
      begin
         p[32*k +: 32] = model[(addr + k) % mem_words];
      end
      return p;
   endfunction

   // unknown expectation means the words were never written
   task automatic check_quad(input string name, input vrf_port_pkg::quad_t exp,
                             input vrf_port_pkg::quad_t act);
      if (!$isunknown(exp) && act !== exp)
      begin
         error_count++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_pair(input string name, input vrf_port_pkg::pair_t exp,
                             input vrf_port_pkg::pair_t act);
      if (!$isunknown(exp) && act !== exp)
      begin
         error_count++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic build_table();
      // fill all 512 words while reading back the quad written one row earlier
      for (int r = 0; r < 128; r++)
         add_row(4*r, 15, 0, 0, (4*r + 508) % mem_words, (4*r + 509) % mem_words);
      // single words at every alignment on both ports followed by wide reads
      for (int k = 0; k < 4; k++)
         add_row(20 + k, 1, 24 + k, 1, 40, 41);
      for (int k = 0; k < 8; k++)
         add_row(0, 0, 0, 0, 20 + k, 19 + k);
      // legal pairs and quads with narrow reads at odd addresses
      add_row(40, 3, 50, 3, 0, 0);
      add_row(44, 15, 510, 3, 0, 0);
      add_row(508, 15, 2, 3, 0, 0);
      for (int k = 0; k < 6; k++)
         add_row(0, 0, 0, 0, 40 + 2*k, 41 + 2*k);
      add_row(0, 0, 0, 0, 509, 511);
      add_row(0, 0, 0, 0, 511, 1);
      // illegal masks and alignments
      add_row(61, 3, 71, 3, 0, 0);
      add_row(62, 15, 72, 2, 0, 0);
      add_row(64, 5, 73, 0, 0, 0);
      add_row(66, 7, 0, 0, 0, 0);
      for (int k = 0; k < 4; k++)
         add_row(0, 0, 0, 0, 60 + 4*k, 71 + k);
      // both ports on the same words
      add_row(80, 15, 82, 3, 0, 0);
      add_row(90, 1, 90, 1, 0, 0);
      add_row(0, 0, 0, 0, 80, 82);
      add_row(0, 0, 0, 0, 88, 90);
      // read on the write edge sees old data and the next read sees the new
      add_row(100, 1, 101, 1, 100, 100);
      add_row(0, 0, 0, 0, 100, 100);
      for (int k = 0; k < 16; k++)
         add_row(200 + k, 1, 0, 0, (37*k + 5) % mem_words, (53*k + 3) % mem_words);
   endtask

   initial
   begin
      stim_t               row;
      vrf_port_pkg::quad_t data0;
      vrf_port_pkg::pair_t data1;
      vrf_port_pkg::quad_t prev_quad;
      vrf_port_pkg::pair_t prev_pair;
      void'($urandom(16229));
      arst_n    = 1'b0;
      rd0_addr  = '0;
      rd1_addr  = '0;
      wr0_addr  = '0;
      wr1_addr  = '0;
      wr0_en    = '0;
      wr1_en    = '0;
      wr0_data  = '0;
      wr1_data  = '0;
      prev_quad = 'x;
      prev_pair = 'x;
      build_table();
      for (int c = 0; c < 4; c++)
         @(posedge clk);
      arst_n <= 1'b1;
      foreach (stim_q[i])
      begin
         row   = stim_q[i];
         data0 = {$urandom(), $urandom(), $urandom(), $urandom()};
         data1 = {$urandom(), $urandom()};
         @(posedge clk);
         wr0_addr <= row.wr0_addr;
         wr0_en   <= row.wr0_en;
         wr0_data <= data0;
         wr1_addr <= row.wr1_addr;
         wr1_en   <= row.wr1_en;
         wr1_data <= data1;
         rd0_addr <= row.rd0_addr;
         rd1_addr <= row.rd1_addr;
         // the previous row's reads are valid between these edges
         @(negedge clk);
         check_quad("rd0_data", prev_quad, rd0_data);
         check_pair("rd1_data", prev_pair, rd1_data);
         prev_quad = model_quad(int'(row.rd0_addr));
         prev_pair = model_pair(int'(row.rd1_addr));
         model_write(int'(row.wr0_addr), int'(row.wr0_en), 4, data0);
         model_write(int'(row.wr1_addr), int'(row.wr1_en), 2, {64'h0, data1});
      end
      @(posedge clk);
      wr0_en <= '0;
      wr1_en <= '0;
      @(negedge clk);
      check_quad("rd0_data", prev_quad, rd0_data);
      check_pair("rd1_data", prev_pair, rd1_data);
      error_count += vector_regfile_inst.wr0_steer_chk.fail_cnt;
      error_count += vector_regfile_inst.wr1_steer_chk.fail_cnt;
      $display("errors: %0d", error_count);
      if (error_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      for (int c = 0; c < max_cycles; c++)
         @(posedge clk);
      $display("timeout: stimulus did not complete within %0d cycles", max_cycles);
      $display("sim failed");
      $finish;
   end

endmodule

// File: filelist.f
src/vrf_geom_pkg.sv
src/vrf_port_pkg.sv
src/vrf_bank.sv
src/vrf_write_steer.sv
src/vrf_read_port.sv
src/vector_regfile.sv
tb/vector_regfile_assert.sv
tb/vector_regfile_tb.sv

// File: Bender.yml
package:
  name: vector_regfile

sources:
  - src/vrf_geom_pkg.sv
  - src/vrf_port_pkg.sv
  - src/vrf_bank.sv
  - src/vrf_write_steer.sv
  - src/vrf_read_port.sv
  - src/vector_regfile.sv
  - target: test
    files:
      - tb/vector_regfile_assert.sv
      - tb/vector_regfile_tb.sv
